// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   // pc and memory word width
   localparam int XLEN = 64;

   // one uncompressed instruction
   localparam int ILEN = 32;

   // read address channel width
   // taken from the low pc bits only
   localparam int ADDR_W = 32;

   // boot address
   localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

   // instruction memory index width
   // 256 words of 64 bits
   // index is address bits 10:3
   // upper bits ignored so addresses wrap
   localparam int IMEM_AW = 8;

   // cycles from accepting edge to rvalid
   // matches the address and data stages in imem
   localparam int IMEM_LATENCY = 2;

   // sequential pc increment
   localparam int PC_STEP = 4;

   // in-flight request pcs held by fetch_req
   // equal to IMEM_LATENCY so requests can go out back-to-back
   localparam int MAX_INFLIGHT = 2;

   // queue pointer width of at least one bit
   localparam int QPTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;

   // occupancy and squash counter width
   // holds 0 up to MAX_INFLIGHT
   localparam int QCNT_W = $clog2(MAX_INFLIGHT + 1);

endpackage

`default_nettype wire

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen import fetch_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic [XLEN-1:0] dnpc,
   input  logic            pc_update,
   input  logic            fire,
   output logic [XLEN-1:0] pc
);

   // next sequential address
   logic [XLEN-1:0] pc_seq;

   // step size widened to pc width
   assign pc_seq = pc + XLEN'(PC_STEP);

   // program counter register
   // redirect wins over the sequential step
   // fire means the current pc was taken by imem, so move past it
   // otherwise hold, e.g. while imem refuses requests during a load
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= RESET_PC;
      end else if (pc_update) begin
         // new target from execute
         pc <= dnpc;
      end else if (fire) begin
         pc <= pc_seq;
      end
   end

   // note that fetch_req never fires in a pc_update cycle,
   // so the redirect target itself is always the next address issued

endmodule

`default_nettype wire

// ==== source/fetch_req.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_req import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic [XLEN-1:0]   pc,
   input  logic              pc_update,
   input  logic              arready,
   input  logic              rvalid,
   output logic              arvalid,
   output logic [ADDR_W-1:0] araddr,
   output logic              fire,
   output logic [XLEN-1:0]   resp_pc,
   output logic              resp_keep
);

   // read data channel, always accepted
   logic              rready;
   logic              pop;
   logic              room;
   // pcs of accepted requests, oldest at rd_ptr
   logic [XLEN-1:0]   pc_q [MAX_INFLIGHT];
   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;
   // responses still to be dropped after a redirect
   logic [QCNT_W-1:0] squash_cnt;

   assign rready = 1'b1;
   assign pop    = rvalid & rready;

   // a popped slot is reusable in the same cycle
   assign room    = (count < QCNT_W'(MAX_INFLIGHT)) | pop;
   // no issue in the redirect cycle, pc is stale there
   assign arvalid = room & ~pc_update;
   assign araddr  = arvalid ? pc[ADDR_W-1:0] : '0;
   assign fire    = arvalid & arready;

   // head of queue pairs with the current response
   assign resp_pc   = pc_q[rd_ptr];
   // a response landing in the redirect cycle is stale as well
   assign resp_keep = (squash_cnt == '0) & ~pc_update;

   // queue pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (fire) begin
            wr_ptr <= (wr_ptr == QPTR_W'(MAX_INFLIGHT - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == QPTR_W'(MAX_INFLIGHT - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({fire, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // queue storage
   always_ff @(posedge clk) begin
      if (fire) begin
         pc_q[wr_ptr] <= pc;
      end
   end

   // squash counter
   // on redirect everything left in flight after this cycle's pop is dead
   always_ff @(posedge clk) begin
      if (rst) begin
         squash_cnt <= '0;
      end else if (pc_update) begin
         squash_cnt <= count - {{(QCNT_W - 1){1'b0}}, pop};
      end else if (pop && squash_cnt != '0) begin
         squash_cnt <= squash_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== source/imem.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem import fetch_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               arvalid,
   input  logic [ADDR_W-1:0]  araddr,
   output logic               arready,
   output logic               rvalid,
   output logic [XLEN-1:0]    rdata,
   input  logic               load_en,
   input  logic [IMEM_AW-1:0] load_addr,
   input  logic [XLEN-1:0]    load_data
);

   // program storage, one 64-bit word per index
   logic [XLEN-1:0]    mem [2**IMEM_AW];
   // set one cycle after reset, memory takes requests from then on
   logic               up;
   logic               accept;
   // address stage
   logic               a_valid;
   logic [IMEM_AW-1:0] a_idx;

   // load port has priority over reads
   assign arready = up & ~load_en;
   assign accept  = arvalid & arready;

   // load port write
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // pipeline valids
   // accept in c, address stage in c+1, data out in c+2
   always_ff @(posedge clk) begin
      if (rst) begin
         up      <= 1'b0;
         a_valid <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         up      <= 1'b1;
         a_valid <= accept;
         rvalid  <= a_valid;
      end
   end

   // address stage
   // word index from bits 10:3, higher bits dropped so the space wraps
   always_ff @(posedge clk) begin
      if (accept) begin
         a_idx <= araddr[IMEM_AW+2:3];
      end
   end

   // data stage, reads in request order
   always_ff @(posedge clk) begin
      if (a_valid) begin
         rdata <= mem[a_idx];
      end
   end

endmodule

`default_nettype wire

// ==== source/inst_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_align import fetch_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            rvalid,
   input  logic [XLEN-1:0] rdata,
   input  logic [XLEN-1:0] resp_pc,
   input  logic            resp_keep,
   output logic [ILEN-1:0] inst,
   output logic [XLEN-1:0] inst_pc,
   output logic            inst_valid
);

   logic            take;
   // pc bit 2 picks the word half
   logic [ILEN-1:0] half;

   assign take = rvalid & resp_keep;
   assign half = resp_pc[2] ? rdata[XLEN-1:ILEN] : rdata[ILEN-1:0];

   // one-cycle strobe per kept response
   always_ff @(posedge clk) begin
      if (rst) begin
         inst_valid <= 1'b0;
      end else begin
         inst_valid <= take;
      end
   end

   // inst reads as zero when nothing valid
   always_ff @(posedge clk) begin
      if (take) begin
         inst    <= half;
         inst_pc <= resp_pc;
      end else begin
         inst    <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic [XLEN-1:0]    dnpc,
   input  logic               pc_update,
   input  logic               load_en,
   input  logic [IMEM_AW-1:0] load_addr,
   input  logic [XLEN-1:0]    load_data,
   output logic [ILEN-1:0]    inst,
   output logic [XLEN-1:0]    inst_pc,
   output logic               inst_valid
);

   // pc_gen and fetch_req
   logic [XLEN-1:0]   pc;
   logic              fire;
   // address channel
   logic              arvalid;
   logic [ADDR_W-1:0] araddr;
   logic              arready;
   // read channel
   logic              rvalid;
   logic [XLEN-1:0]   rdata;
   // response tag from the pc queue
   logic [XLEN-1:0]   resp_pc;
   logic              resp_keep;

   pc_gen i_pc_gen (
      .clk       (clk),
      .rst       (rst),
      .dnpc      (dnpc),
      .pc_update (pc_update),
      .fire      (fire),
      .pc        (pc)
   );

   fetch_req i_fetch_req (
      .clk       (clk),
      .rst       (rst),
      .pc        (pc),
      .pc_update (pc_update),
      .arready   (arready),
      .rvalid    (rvalid),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .fire      (fire),
      .resp_pc   (resp_pc),
      .resp_keep (resp_keep)
   );

   imem i_imem (
      .clk       (clk),
      .rst       (rst),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arready   (arready),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   inst_align i_inst_align (
      .clk        (clk),
      .rst        (rst),
      .rvalid     (rvalid),
      .rdata      (rdata),
      .resp_pc    (resp_pc),
      .resp_keep  (resp_keep),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 3
) (
   input  logic hold,
   output logic clk,
   output logic rst
);

   // free running clock, first rising edge at half a period
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset stays high while hold is high, then RST_CYCLES more cycles
   // released on a falling edge like every other input
   initial begin
      rst = 1'b1;
      wait (!hold);
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 3;
   // first cycle of an issue to the shown instruction
   localparam int FETCH_LAT  = 4;
   localparam int FILL_CYC   = 2**IMEM_AW;
   localparam int SEQ_CYC    = 200;
   localparam int WRAP_CYC   = 10;
   localparam int RAND_CYC   = 600;
   localparam int DRAIN_CYC  = 10;
   localparam int TOTAL_CYC  =
      FILL_CYC + 1 + RST_CYCLES + SEQ_CYC + WRAP_CYC + RAND_CYC + DRAIN_CYC;
   // a load in cycle j is seen by instructions shown from j+3 on
   localparam int WR_SEEN    = IMEM_LATENCY + 1;

   logic               hold;
   logic               clk;
   logic               rst;
   logic [XLEN-1:0]    dnpc;
   logic               pc_update;
   logic               load_en;
   logic [IMEM_AW-1:0] load_addr;
   logic [XLEN-1:0]    load_data;
   logic [ILEN-1:0]    inst;
   logic [XLEN-1:0]    inst_pc;
   logic               inst_valid;

   // memory mirror and expected fetch stream
   logic [XLEN-1:0]    model [2**IMEM_AW];
   logic [XLEN-1:0]    exp_pc;
   logic [31:0]        lfsr;
   int                 cyc;
   int                 errors;
   int                 checks;
   int                 n_inst;
   bit                 first_seen;
   bit                 redir_wait;
   int                 redir_cyc;
   bit                 stream_on;
   string              phase;
   int                 load_left;
   int                 quiet;
   logic [XLEN-1:0]    sel;
   logic [XLEN-1:0]    off;
   // loads waiting to reach the mirror
   int                 wr_cyc_q [$];
   logic [IMEM_AW-1:0] wr_idx_q [$];
   logic [XLEN-1:0]    wr_dat_q [$];

   tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_tb_clock (
      .hold (hold),
      .clk  (clk),
      .rst  (rst)
   );

   fetch_top i_fetch_top (
      .clk        (clk),
      .rst        (rst),
      .dnpc       (dnpc),
      .pc_update  (pc_update),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid)
   );

   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one step per bit taken
   function automatic logic [XLEN-1:0] rand_bits(input int n);
      logic [XLEN-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[XLEN-2:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic compare(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s expected %h actual %h at cycle %0d", name, exp, act, cyc);
      end
   endtask

   // memory write lands after the read of any earlier request
   task automatic apply_loads();
      while (wr_cyc_q.size() > 0 && wr_cyc_q[0] + WR_SEEN <= cyc) begin
         model[wr_idx_q[0]] = wr_dat_q[0];
         void'(wr_cyc_q.pop_front());
         void'(wr_idx_q.pop_front());
         void'(wr_dat_q.pop_front());
      end
   endtask

   task automatic observe();
      logic [XLEN-1:0] word;
      logic [ILEN-1:0] half;
      apply_loads();
      if (stream_on && cyc >= FETCH_LAT) begin
         compare({phase, " stream"}, 1, inst_valid);
      end
      if (!inst_valid) begin
         compare({phase, " idle inst"}, 0, inst);
      end else begin
         if (!first_seen) begin
            compare("first fetch cycle", FETCH_LAT, cyc);
            first_seen = 1'b1;
         end
         if (redir_wait) begin
            compare({phase, " redirect latency"}, FETCH_LAT, cyc - redir_cyc);
            redir_wait = 1'b0;
         end
         // word index is pc bits 10:3, so high bits wrap; bit 2 picks the half
         word = model[exp_pc[IMEM_AW+2:3]];
         half = exp_pc[2] ? word[XLEN-1:ILEN] : word[ILEN-1:0];
         compare({phase, " inst_pc"}, exp_pc, inst_pc);
         compare({phase, " inst"}, half, inst);
         exp_pc = exp_pc + 4;
         n_inst++;
      end
   endtask

   // outputs checked before inputs change, all on the falling edge
   task automatic next_cycle();
      @(negedge clk);
      cyc++;
      observe();
   endtask

   // this cycle's output is pre-redirect and already checked
   task automatic redirect(input logic [XLEN-1:0] target);
      pc_update  = 1'b1;
      dnpc       = target;
      exp_pc     = target;
      redir_cyc  = cyc;
      redir_wait = 1'b1;
   endtask

   task automatic load_word();
      load_en   = 1'b1;
      load_addr = rand_bits(IMEM_AW);
      load_data = rand_bits(XLEN);
      wr_cyc_q.push_back(cyc);
      wr_idx_q.push_back(load_addr);
      wr_dat_q.push_back(load_data);
   endtask

   initial begin
      hold       = 1'b1;
      dnpc       = '0;
      pc_update  = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      lfsr       = 32'd89;
      cyc        = 0;
      errors     = 0;
      checks     = 0;
      n_inst     = 0;
      first_seen = 1'b0;
      redir_wait = 1'b0;
      redir_cyc  = 0;
      stream_on  = 1'b0;
      load_left  = 0;
      quiet      = 0;
      exp_pc     = RESET_PC;
      phase      = "reset";
      // program fill while the fetch side is held in reset
      for (int i = 0; i < FILL_CYC; i++) begin
         @(negedge clk);
         compare("reset quiet", 0, inst_valid);
         load_en   = 1'b1;
         load_addr = IMEM_AW'(i);
         load_data = rand_bits(XLEN);
         model[i]  = load_data;
      end
      @(negedge clk);
      load_en = 1'b0;
      hold    = 1'b0;
      // cycle 0 is the first one with rst low
      @(negedge rst);
      cyc = 0;

      // straight line fetch from the boot address, one strobe per cycle
      phase     = "sequential";
      stream_on = 1'b1;
      repeat (SEQ_CYC) next_cycle();
      stream_on = 1'b0;

      // target past the 2 KB memory, index wraps
      phase = "wrap";
      next_cycle();
      redirect(RESET_PC + 64'h31ac);
      repeat (WRAP_CYC - 1) begin
         next_cycle();
         pc_update = 1'b0;
      end

      // redirects and load bursts mixed, no load within a redirect's window
      phase = "random";
      for (int n = 0; n < RAND_CYC; n++) begin
         next_cycle();
         pc_update = 1'b0;
         if (load_left > 0) begin
            load_word();
            load_left--;
         end else begin
            load_en = 1'b0;
            if (quiet > 0) begin
               quiet--;
            end else begin
               sel = rand_bits(4);
               off = rand_bits(9) << 2;
               if (sel == 0) begin
                  redirect(RESET_PC + off);
                  quiet = 6;
               end else if (sel == 1) begin
                  redirect(RESET_PC + ((rand_bits(4) + 1) << 11) + off);
                  quiet = 6;
               end else if (sel == 2 || sel == 3) begin
                  // burst of 1 to 8 words
                  load_left = rand_bits(3);
                  load_word();
               end
            end
         end
      end

      phase = "drain";
      repeat (DRAIN_CYC) begin
         next_cycle();
         pc_update = 1'b0;
         load_en   = 1'b0;
      end

      if (redir_wait) begin
         errors++;
         $display("the instruction at the last redirect target never arrived");
      end
      if (!first_seen) begin
         errors++;
         $display("no instruction was ever delivered");
      end
      $display("checks %0d errors %0d instructions %0d", checks, errors, n_inst);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // bound on the whole run
   initial begin
      #((TOTAL_CYC + 100) * CLK_PERIOD);
      $display("run timed out after %0d cycles without reaching the end", TOTAL_CYC + 100);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_req.sv
source/imem.sv
source/inst_align.sv
source/fetch_top.sv
dv/tb_clock.sv
dv/fetch_tb.sv
